/* sources.f */
common/wrb_pkg.sv
common/release_if.sv
source/slot_allocator.sv
source/slot_ram.sv
linked_list/list_ctrl.sv
linked_list/release_arbiter.sv
source/output_stage.sv
source/write_resp_bank.sv
dv/write_resp_bank_props.sv
dv/tb_write_resp_bank.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the write-response bank testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_write_resp_bank \
  -f sources.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -qx "All tests passed!" sim.log && echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }

/* dv/tb_write_resp_bank.sv */
/*
 * Testbench for the write-response bank: stimulus tasks, reference model,
 * compare process and watchdog
 */
module tb_write_resp_bank;

  localparam int unsigned NumTests = 6;
  localparam int unsigned CyclesPerTest = 400;
  localparam int unsigned Period = 40;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  wrb_pkg::id_t res_id_i = '0;
  logic res_ready_i = 1'b0;
  logic res_valid_o;
  wrb_pkg::addr_t res_addr_o;
  wrb_pkg::msg_t in_data_i = '0;
  logic in_valid_i = 1'b0;
  logic in_ready_o;
  wrb_pkg::slot_vec_t release_en_i = '1;
  wrb_pkg::msg_t out_data_o;
  logic out_valid_o;
  logic out_ready_i = 1'b1;
  logic released_valid_o;
  wrb_pkg::addr_t released_addr_o;

  // Reference model keeps one ring of reserved slots per ID
  wrb_pkg::addr_t mdl_addr [wrb_pkg::NumIds][wrb_pkg::Capacity];
  wrb_pkg::msg_t mdl_msg [wrb_pkg::NumIds][wrb_pkg::Capacity];
  int mdl_head [wrb_pkg::NumIds];
  int mdl_cnt [wrb_pkg::NumIds];
  int mdl_nfill [wrb_pkg::NumIds];
  wrb_pkg::slot_vec_t mdl_occ;
  logic mdl_active;
  logic mdl_out_valid;
  wrb_pkg::msg_t mdl_out_data;
  int errors = 0;
  int test_errors;
  string cur_test = "reset";

  write_resp_bank i_write_resp_bank (.*);

  always #(Period / 2) clk_i = !clk_i;

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch in %s: %s expected %b actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string what, input wrb_pkg::addr_t exp,
                            input wrb_pkg::addr_t act);
    if (exp !== act) begin
      $display("Mismatch in %s: %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_msg(input string what, input wrb_pkg::msg_t exp,
                           input wrb_pkg::msg_t act);
    if (exp !== act) begin
      $display("Mismatch in %s: %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  // Valid bit on top of the lowest ID whose oldest slot is filled and enabled
  function automatic logic [wrb_pkg::IdWidth:0] expected_grant(input logic take);
    logic [wrb_pkg::IdWidth:0] pick;
    pick = '0;
    for (int i = wrb_pkg::NumIds - 1; i >= 0; i--) begin
      if (mdl_nfill[i] != 0 && release_en_i[mdl_addr[i][mdl_head[i]]]) begin
        pick = {take, wrb_pkg::id_t'(i)};
      end
    end
    return pick;
  endfunction

  function automatic wrb_pkg::addr_t lowest_free();
    wrb_pkg::addr_t a;
    a = '0;
    for (int i = wrb_pkg::Capacity - 1; i >= 0; i--) begin
      if (!mdl_occ[i]) begin
        a = wrb_pkg::addr_t'(i);
      end
    end
    return a;
  endfunction

  // Compare mid-cycle, then advance the model to the next edge
  always @(negedge clk_i) begin
    logic [wrb_pkg::IdWidth:0] g;
    logic exp_any;
    wrb_pkg::addr_t free_a;
    wrb_pkg::id_t gid;
    wrb_pkg::id_t iid;
    int fidx;
    int ridx;
    if (!rst_ni) begin
      mdl_occ = '0;
      mdl_active = 1'b0;
      mdl_out_valid = 1'b0;
      for (int i = 0; i < wrb_pkg::NumIds; i++) begin
        mdl_head[i] = 0;
        mdl_cnt[i] = 0;
        mdl_nfill[i] = 0;
      end
    end else begin
      exp_any = mdl_active && !(&mdl_occ);
      free_a = lowest_free();
      g = expected_grant(!mdl_out_valid || out_ready_i);
      gid = g[wrb_pkg::IdWidth-1:0];
      iid = in_data_i[wrb_pkg::IdWidth-1:0];
      check_bit("res_valid_o", exp_any, res_valid_o);
      if (exp_any) check_addr("res_addr_o", free_a, res_addr_o);
      check_bit("out_valid_o", mdl_out_valid, out_valid_o);
      if (mdl_out_valid) check_msg("out_data_o", mdl_out_data, out_data_o);
      check_bit("released_valid_o", g[wrb_pkg::IdWidth], released_valid_o);
      if (g[wrb_pkg::IdWidth]) begin
        check_addr("released_addr_o", mdl_addr[gid][mdl_head[gid]], released_addr_o);
      end
      if (mdl_cnt[iid] == mdl_nfill[iid] || (g[wrb_pkg::IdWidth] && gid == iid)) begin
        check_bit("in_ready_o", 1'b0, in_ready_o);
      end
      fidx = (mdl_head[iid] + mdl_nfill[iid]) % wrb_pkg::Capacity;
      ridx = (mdl_head[res_id_i] + mdl_cnt[res_id_i]) % wrb_pkg::Capacity;
      if (in_valid_i && in_ready_o && mdl_cnt[iid] > mdl_nfill[iid]) begin
        mdl_msg[iid][fidx] = in_data_i;
        mdl_nfill[iid]++;
      end
      if (exp_any && res_ready_i) begin
        mdl_addr[res_id_i][ridx] = free_a;
        mdl_cnt[res_id_i]++;
        mdl_occ[free_a] = 1'b1;
      end
      if (g[wrb_pkg::IdWidth]) begin
        mdl_out_data = mdl_msg[gid][mdl_head[gid]];
        mdl_out_valid = 1'b1;
        mdl_occ[mdl_addr[gid][mdl_head[gid]]] = 1'b0;
        mdl_head[gid] = (mdl_head[gid] + 1) % wrb_pkg::Capacity;
        mdl_cnt[gid]--;
        mdl_nfill[gid]--;
      end else if (out_ready_i) begin
        mdl_out_valid = 1'b0;
      end
      mdl_active = 1'b1;
    end
  end

  task automatic next_cycle(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  task automatic reserve(input wrb_pkg::id_t id, output wrb_pkg::addr_t addr);
    res_id_i = id;
    res_ready_i = 1'b1;
    do @(negedge clk_i); while (!res_valid_o);
    addr = res_addr_o;
    next_cycle(1);
    res_ready_i = 1'b0;
  endtask

  task automatic send(input wrb_pkg::id_t id);
    in_data_i = ($urandom() & ~32'(wrb_pkg::NumIds - 1)) | 32'(id);
    in_valid_i = 1'b1;
    do @(negedge clk_i); while (!in_ready_o);
    next_cycle(1);
    in_valid_i = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((mdl_out_valid || (mdl_cnt[0] + mdl_cnt[1] + mdl_cnt[2] + mdl_cnt[3]) != 0)
           && n < 200) begin
      next_cycle(1);
      n++;
    end
    if (n == 200) begin
      $display("Bank did not drain in %s", cur_test);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    $display("%s finished with %0d errors", cur_test, errors - test_errors);
  endtask

  initial begin
    wrb_pkg::addr_t a;
    wrb_pkg::addr_t held;
    wrb_pkg::msg_t stalled;
    void'($urandom(86267));
    next_cycle(10);
    rst_ni = 1'b1;
    next_cycle(1);

    // Lowest free addresses in turn, then fills in reservation order
    start_test("reserve_and_fill");
    for (int i = 0; i < 6; i++) reserve(wrb_pkg::id_t'(i % 3), a);
    in_data_i = 32'(3);
    @(negedge clk_i);
    check_bit("in_ready_o for unreserved ID", 1'b0, in_ready_o);
    next_cycle(1);
    for (int i = 0; i < 6; i++) send(wrb_pkg::id_t'(i % 3));
    drain();
    end_test();

    // Competing IDs, all filled before the enables open
    start_test("release_order");
    for (int i = 0; i < 8; i++) reserve(wrb_pkg::id_t'(3 - (i % 4)), a);
    release_en_i = '0;
    for (int i = 0; i < 8; i++) send(wrb_pkg::id_t'(3 - (i % 4)));
    release_en_i = '1;
    drain();
    end_test();

    start_test("enable_hold");
    reserve(wrb_pkg::id_t'(1), held);
    reserve(wrb_pkg::id_t'(1), a);
    reserve(wrb_pkg::id_t'(2), a);
    release_en_i[held] = 1'b0;
    send(wrb_pkg::id_t'(1));
    send(wrb_pkg::id_t'(1));
    send(wrb_pkg::id_t'(2));
    do @(negedge clk_i); while (!released_valid_o);
    check_addr("other ID released", a, released_addr_o);
    next_cycle(10);
    release_en_i = '1;
    do @(negedge clk_i); while (!released_valid_o);
    check_addr("held slot released", held, released_addr_o);
    drain();
    end_test();

    start_test("back_pressure");
    out_ready_i = 1'b0;
    reserve(wrb_pkg::id_t'(0), a);
    reserve(wrb_pkg::id_t'(0), a);
    send(wrb_pkg::id_t'(0));
    send(wrb_pkg::id_t'(0));
    @(negedge clk_i);
    stalled = out_data_o;
    repeat (8) begin
      @(negedge clk_i);
      check_msg("stalled out_data_o", stalled, out_data_o);
      check_bit("release under stall", 1'b0, released_valid_o);
    end
    next_cycle(1);
    out_ready_i = 1'b1;
    drain();
    end_test();

    // Full bank with one slot freed and reserved again
    start_test("full_bank");
    for (int i = 0; i < 16; i++) reserve(wrb_pkg::id_t'(i % 4), a);
    @(negedge clk_i);
    check_bit("res_valid_o when full", 1'b0, res_valid_o);
    next_cycle(1);
    send(wrb_pkg::id_t'(0));
    do @(negedge clk_i); while (!released_valid_o);
    held = released_addr_o;
    next_cycle(1);
    reserve(wrb_pkg::id_t'(0), a);
    check_addr("reserved after free", held, a);
    for (int i = 1; i < 17; i++) send(wrb_pkg::id_t'(i % 4));
    drain();
    end_test();

    start_test("random_mix");
    for (int i = 0; i < 12; i++) reserve(wrb_pkg::id_t'($urandom() % 4), a);
    for (int i = 0; i < 4; i++) begin
      while (mdl_cnt[i] > mdl_nfill[i]) send(wrb_pkg::id_t'(i));
    end
    drain();
    end_test();

    $display("%0d tests run, %0d errors", NumTests, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #((NumTests * CyclesPerTest + 10 + 100) * Period);
    $display("Watchdog expired before the tests completed");
    $display("Test failures found");
    $finish;
  end

endmodule

/* dv/write_resp_bank_props.sv */
/*
 * Concurrent assertions on list counts, input ready and grant gating
 */
module write_resp_bank_props (
  input logic          clk_i,
  input logic          rst_ni,
  input wrb_pkg::cnt_t filled_i   [wrb_pkg::NumIds],
  input wrb_pkg::cnt_t unfilled_i [wrb_pkg::NumIds],
  input logic          in_ready_i,
  input wrb_pkg::id_t  in_id_i,
  input logic          grant_valid_i,
  input logic          take_ready_i
);

  // Filled slots of an ID are always part of its reservations
  for (genvar i = 0; i < wrb_pkg::NumIds; i++) begin : gen_cnt
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (int'(filled_i[i]) + int'(unfilled_i[i])) <= wrb_pkg::Capacity)
      else $error("filled count of ID %0d exceeds its reservations", i);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_i |-> (unfilled_i[in_id_i] != '0))
    else $error("in_ready_o high without a reserved unfilled slot");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    grant_valid_i |-> take_ready_i)
    else $error("grant while the output register cannot take");

endmodule

bind write_resp_bank write_resp_bank_props i_write_resp_bank_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .filled_i      (i_list_ctrl.filled_q),
  .unfilled_i    (i_list_ctrl.unfilled_q),
  .in_ready_i    (in_ready_o),
  .in_id_i       (in_id),
  .grant_valid_i (i_release_if.grant_valid),
  .take_ready_i  (take_ready)
);

/* source/write_resp_bank.sv */
/*
 * Write-response bank top: slot allocator, message and next-pointer RAMs,
 * list controller, release arbiter and output register
 */
module write_resp_bank (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Reservation
  input  wrb_pkg::id_t       res_id_i,
  input  logic               res_ready_i,
  output logic               res_valid_o,
  output wrb_pkg::addr_t     res_addr_o,
  // Incoming messages
  input  wrb_pkg::msg_t      in_data_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  wrb_pkg::slot_vec_t release_en_i,
  // Outgoing messages
  output wrb_pkg::msg_t      out_data_o,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  // Freed slot pulse
  output logic               released_valid_o,
  output wrb_pkg::addr_t     released_addr_o
);

  logic           res_fire;
  wrb_pkg::id_t   in_id;
  logic           msg_we;
  wrb_pkg::addr_t msg_waddr;
  wrb_pkg::msg_t  msg_rdata;
  logic           next_we;
  wrb_pkg::addr_t next_waddr;
  wrb_pkg::addr_t next_wdata;
  wrb_pkg::addr_t next_raddr;
  wrb_pkg::addr_t next_rdata;
  wrb_pkg::addr_t grant_addr;
  logic           take_ready;

  release_if i_release_if ();

  assign res_fire         = res_valid_o && res_ready_i;
  assign in_id            = in_data_i[wrb_pkg::IdWidth-1:0];
  assign released_valid_o = i_release_if.grant_valid;
  assign released_addr_o  = grant_addr;

  slot_allocator i_slot_allocator (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .alloc_i      (res_fire),
    .free_valid_i (i_release_if.grant_valid),
    .free_addr_i  (grant_addr),
    .any_free_o   (res_valid_o),
    .free_addr_o  (res_addr_o)
  );

  slot_ram #(.payload_t(wrb_pkg::msg_t)) i_msg_ram (
    .clk_i   (clk_i),
    .we_i    (msg_we),
    .waddr_i (msg_waddr),
    .wdata_i (in_data_i),
    .raddr_i (grant_addr),
    .rdata_o (msg_rdata)
  );

  slot_ram #(.payload_t(wrb_pkg::addr_t)) i_next_ram (
    .clk_i   (clk_i),
    .we_i    (next_we),
    .waddr_i (next_waddr),
    .wdata_i (next_wdata),
    .raddr_i (next_raddr),
    .rdata_o (next_rdata)
  );

  list_ctrl i_list_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res_fire_i   (res_fire),
    .res_id_i     (res_id_i),
    .res_addr_i   (res_addr_o),
    .in_valid_i   (in_valid_i),
    .in_id_i      (in_id),
    .in_ready_o   (in_ready_o),
    .msg_we_o     (msg_we),
    .msg_waddr_o  (msg_waddr),
    .rel          (i_release_if.list),
    .next_we_o    (next_we),
    .next_waddr_o (next_waddr),
    .next_wdata_o (next_wdata),
    .next_raddr_o (next_raddr),
    .next_rdata_i (next_rdata)
  );

  release_arbiter i_release_arbiter (
    .release_en_i (release_en_i),
    .take_ready_i (take_ready),
    .rel          (i_release_if.arb),
    .grant_addr_o (grant_addr)
  );

  output_stage i_output_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (i_release_if.grant_valid),
    .data_i       (msg_rdata),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .out_data_o   (out_data_o),
    .take_ready_o (take_ready)
  );

endmodule

/* source/output_stage.sv */
/*
 * One-entry output register with valid/ready
 */
module output_stage (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          load_i,
  input  wrb_pkg::msg_t data_i,
  input  logic          out_ready_i,
  output logic          out_valid_o,
  output wrb_pkg::msg_t out_data_o,
  output logic          take_ready_o
);

  logic          valid_q;
  wrb_pkg::msg_t data_q;

  // Empty, or the held message leaves at this edge
  assign take_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load_i) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      data_q <= data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

/* linked_list/release_arbiter.sv */
/*
 * Picks the ID and slot to release this cycle, lowest candidate ID first
 */
module release_arbiter (
  input  wrb_pkg::slot_vec_t release_en_i,
  input  logic               take_ready_i,
  release_if.arb             rel,
  output wrb_pkg::addr_t     grant_addr_o
);

  wrb_pkg::id_vec_t candidates;

  // Oldest filled slot of the ID must have its enable set
  always_comb begin
    for (int i = 0; i < wrb_pkg::NumIds; i++) begin
      candidates[i] = rel.ready_ids[i] && rel.head_is_filled[i] &&
                      release_en_i[rel.tails[i]];
    end
  end

  // Lowest ID wins
  always_comb begin
    rel.grant_id = '0;
    for (int i = wrb_pkg::NumIds - 1; i >= 0; i--) begin
      if (candidates[i]) begin
        rel.grant_id = wrb_pkg::id_t'(i);
      end
    end
  end

  assign rel.grant_valid = take_ready_i && (|candidates);
  assign grant_addr_o    = rel.tails[rel.grant_id];

endmodule

/* linked_list/list_ctrl.sv */
/*
 * Per-ID linked lists over the shared slots: last-reserved, fill and
 * tail pointers, reserved-unfilled and filled counts, next-pointer writes
 */
module list_ctrl (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           res_fire_i,
  input  wrb_pkg::id_t   res_id_i,
  input  wrb_pkg::addr_t res_addr_i,
  input  logic           in_valid_i,
  input  wrb_pkg::id_t   in_id_i,
  output logic           in_ready_o,
  output logic           msg_we_o,
  output wrb_pkg::addr_t msg_waddr_o,
  release_if.list        rel,
  output logic           next_we_o,
  output wrb_pkg::addr_t next_waddr_o,
  output wrb_pkg::addr_t next_wdata_o,
  output wrb_pkg::addr_t next_raddr_o,
  input  wrb_pkg::addr_t next_rdata_i
);

  wrb_pkg::addr_t last_res_d [wrb_pkg::NumIds];
  wrb_pkg::addr_t last_res_q [wrb_pkg::NumIds];
  wrb_pkg::addr_t fill_ptr_d [wrb_pkg::NumIds];
  wrb_pkg::addr_t fill_ptr_q [wrb_pkg::NumIds];
  wrb_pkg::addr_t tail_d     [wrb_pkg::NumIds];
  wrb_pkg::addr_t tail_q     [wrb_pkg::NumIds];
  wrb_pkg::cnt_t  unfilled_d [wrb_pkg::NumIds];
  wrb_pkg::cnt_t  unfilled_q [wrb_pkg::NumIds];
  wrb_pkg::cnt_t  filled_d   [wrb_pkg::NumIds];
  wrb_pkg::cnt_t  filled_q   [wrb_pkg::NumIds];

  wrb_pkg::id_vec_t res_hit;
  wrb_pkg::id_vec_t fill_hit;
  wrb_pkg::id_vec_t grant_hit;
  logic             tail_needs_read;
  logic             fill_stall;
  logic             fill_fire;

  // A tail with more than one filled slot behind it follows its next pointer
  assign tail_needs_read = rel.grant_valid && (filled_q[rel.grant_id] > wrb_pkg::cnt_t'(1));

  // Grant owns the read port, and a fill of the granted ID always waits
  assign fill_stall = rel.grant_valid &&
                      ((rel.grant_id == in_id_i) ||
                       (tail_needs_read && (unfilled_q[in_id_i] > wrb_pkg::cnt_t'(1))));

  assign in_ready_o = (unfilled_q[in_id_i] != '0) && !fill_stall;
  assign fill_fire  = in_valid_i && in_ready_o;

  assign msg_we_o    = fill_fire;
  assign msg_waddr_o = fill_ptr_q[in_id_i];

  // Link a new slot behind the last reserved one of a non-empty list
  assign next_we_o    = res_fire_i && ((unfilled_q[res_id_i] + filled_q[res_id_i]) != '0);
  assign next_waddr_o = last_res_q[res_id_i];
  assign next_wdata_o = res_addr_i;
  assign next_raddr_o = tail_needs_read ? tail_q[rel.grant_id] : fill_ptr_q[in_id_i];

  // Fills go in order, so the oldest reserved slot is filled once any is
  for (genvar i = 0; i < wrb_pkg::NumIds; i++) begin : gen_rel
    assign rel.ready_ids[i]      = filled_q[i] != '0;
    assign rel.head_is_filled[i] = filled_q[i] != '0;
    assign rel.tails[i]          = tail_q[i];
  end

  always_comb begin
    for (int i = 0; i < wrb_pkg::NumIds; i++) begin
      res_hit[i]   = res_fire_i && (res_id_i == wrb_pkg::id_t'(i));
      fill_hit[i]  = fill_fire && (in_id_i == wrb_pkg::id_t'(i));
      grant_hit[i] = rel.grant_valid && (rel.grant_id == wrb_pkg::id_t'(i));

      unfilled_d[i] = unfilled_q[i] + wrb_pkg::cnt_t'(res_hit[i]) -
                      wrb_pkg::cnt_t'(fill_hit[i]);
      filled_d[i]   = filled_q[i] + wrb_pkg::cnt_t'(fill_hit[i]) -
                      wrb_pkg::cnt_t'(grant_hit[i]);
      last_res_d[i] = res_hit[i] ? res_addr_i : last_res_q[i];

      // Fill pointer walks the list, or takes a new slot when none is left
      fill_ptr_d[i] = fill_ptr_q[i];
      if (fill_hit[i]) begin
        fill_ptr_d[i] = next_rdata_i;
      end
      if (res_hit[i] && (unfilled_d[i] == wrb_pkg::cnt_t'(1))) begin
        fill_ptr_d[i] = res_addr_i;
      end

      tail_d[i] = tail_q[i];
      if (grant_hit[i]) begin
        tail_d[i] = next_rdata_i;
      end
      // First filled slot after the list drained
      if (fill_hit[i] && (filled_q[i] == '0)) begin
        tail_d[i] = fill_ptr_q[i];
      end
      if (res_hit[i] && (unfilled_q[i] == '0) && (filled_q[i] == '0)) begin
        tail_d[i] = res_addr_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < wrb_pkg::NumIds; i++) begin
        last_res_q[i] <= '0;
        fill_ptr_q[i] <= '0;
        tail_q[i]     <= '0;
        unfilled_q[i] <= '0;
        filled_q[i]   <= '0;
      end
    end else begin
      last_res_q <= last_res_d;
      fill_ptr_q <= fill_ptr_d;
      tail_q     <= tail_d;
      unfilled_q <= unfilled_d;
      filled_q   <= filled_d;
    end
  end

endmodule

/* source/slot_ram.sv */
/*
 * Flop-based slot array, one write port and one combinational read port
 */
module slot_ram #(
  parameter type payload_t = logic
) (
  input  logic           clk_i,
  input  logic           we_i,
  input  wrb_pkg::addr_t waddr_i,
  input  payload_t       wdata_i,
  input  wrb_pkg::addr_t raddr_i,
  output payload_t       rdata_o
);

  payload_t mem_q [wrb_pkg::Capacity];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Read sees the old content when the same entry is written this cycle
  assign rdata_o = mem_q[raddr_i];

endmodule

/* source/slot_allocator.sv */
/*
 * Slot occupancy bits with a lowest-free-slot priority search
 */
module slot_allocator (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           alloc_i,
  input  logic           free_valid_i,
  input  wrb_pkg::addr_t free_addr_i,
  output logic           any_free_o,
  output wrb_pkg::addr_t free_addr_o
);

  wrb_pkg::slot_vec_t occupied_d;
  wrb_pkg::slot_vec_t occupied_q;
  // Low during reset, so nothing is offered before the bank runs
  logic               active_q;

  // Lowest free slot wins
  always_comb begin
    free_addr_o = '0;
    for (int i = wrb_pkg::Capacity - 1; i >= 0; i--) begin
      if (!occupied_q[i]) begin
        free_addr_o = wrb_pkg::addr_t'(i);
      end
    end
  end

  assign any_free_o = active_q && !(&occupied_q);

  // A freed slot is occupied and so never matches the allocated one
  always_comb begin
    occupied_d = occupied_q;
    if (alloc_i) begin
      occupied_d[free_addr_o] = 1'b1;
    end
    if (free_valid_i) begin
      occupied_d[free_addr_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
      active_q   <= 1'b0;
    end else begin
      occupied_q <= occupied_d;
      active_q   <= 1'b1;
    end
  end

endmodule

/* common/release_if.sv */
/*
 * Release path between the list controller and the release arbiter
 */
interface release_if;

  // Per-ID list state from the list controller
  wrb_pkg::id_vec_t ready_ids;
  wrb_pkg::addr_t   tails [wrb_pkg::NumIds];
  wrb_pkg::id_vec_t head_is_filled;

  // Grant decision from the arbiter
  logic             grant_valid;
  wrb_pkg::id_t     grant_id;

  modport list (
    output ready_ids, tails, head_is_filled,
    input  grant_valid, grant_id
  );

  modport arb (
    input  ready_ids, tails, head_is_filled,
    output grant_valid, grant_id
  );

endinterface

/* common/wrb_pkg.sv */
/*
 * Sizes and types shared by the write-response bank:
 * ID, slot address, per-ID count, message and bit-vector types
 */
package wrb_pkg;

  // AXI ID
  localparam int unsigned IdWidth = 2;
  localparam int unsigned NumIds = 1 << IdWidth;

  // Shared slot memory
  localparam int unsigned Capacity = 16;
  localparam int unsigned AddrWidth = $clog2(Capacity);

  // The ID sits in the low bits of each message
  localparam int unsigned MessageWidth = 32;

  typedef logic [IdWidth-1:0] id_t;

  typedef logic [AddrWidth-1:0] addr_t;

  // Counts 0 up to Capacity inclusive
  typedef logic [AddrWidth:0] cnt_t;

  typedef logic [MessageWidth-1:0] msg_t;

  // One bit per slot for occupancy and release enables
  typedef logic [Capacity-1:0] slot_vec_t;

  typedef logic [NumIds-1:0] id_vec_t;

endpackage
